// File: design/idu_pkg.sv
`default_nettype none

package idu_pkg;

  localparam int INST_W     = 32;
  localparam int REG_ADDR_W = 4; // rv32e has 16 registers.
  localparam int NUM_REGS   = 2 ** REG_ADDR_W;

  // instruction field positions.
  localparam int OPCODE_LSB = 0;
  localparam int OPCODE_W   = 7;
  localparam int RD_LSB     = 7;
  localparam int FUNCT3_LSB = 12;
  localparam int FUNCT3_W   = 3;
  localparam int RS1_LSB    = 15;
  localparam int RS2_LSB    = 20;
  localparam int ALT_BIT    = 30; // funct7[5] picks sub and sra.
  localparam int SIGN_BIT   = 31;

  localparam logic [INST_W-1:0] EBREAK_INST = 32'h0010_0073;

  // major opcodes of rv32.
  typedef enum logic [OPCODE_W-1:0] {
    OPC_LOAD   = 7'b000_0011,
    OPC_OP_IMM = 7'b001_0011,
    OPC_AUIPC  = 7'b001_0111,
    OPC_STORE  = 7'b010_0011,
    OPC_OP     = 7'b011_0011,
    OPC_LUI    = 7'b011_0111,
    OPC_BRANCH = 7'b110_0011,
    OPC_JALR   = 7'b110_0111,
    OPC_JAL    = 7'b110_1111,
    OPC_SYSTEM = 7'b111_0011
  } opcode_e;

  // execute unit operation with the branch compares last.
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9,
    ALU_BEQ  = 4'd10,
    ALU_BNE  = 4'd11,
    ALU_BLT  = 4'd12,
    ALU_BGE  = 4'd13,
    ALU_BLTU = 4'd14,
    ALU_BGEU = 4'd15
  } alu_op_e;

endpackage

`default_nettype wire

// File: design/decode_if.sv
`timescale 1ns/100ps
`default_nettype none

interface decode_if #(
  parameter int XLEN = 32
) ();
  import idu_pkg::*;

  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  logic [REG_ADDR_W-1:0] rd;
  logic [XLEN-1:0]       imm;
  alu_op_e               alu_op;
  logic                  uses_rs; // low when no source register is read.
  logic                  wen;
  logic                  ren;
  logic                  jen;
  logic                  system;
  logic                  system_func3_zero;
  logic                  csr_wen;
  logic                  ebreak;

  modport dec (
    output rs1, rs2, rd, imm, alu_op, uses_rs,
    output wen, ren, jen, system, system_func3_zero, csr_wen, ebreak
  );

  modport stage (
    input rs1, rs2, rd, imm, alu_op, uses_rs,
    input wen, ren, jen, system, system_func3_zero, csr_wen, ebreak
  );

endinterface

`default_nettype wire

// File: design/operand_if.sv
`timescale 1ns/100ps
`default_nettype none

interface operand_if #(
  parameter int XLEN = 32
) ();
  import idu_pkg::*;

  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  logic                  uses_rs;
  logic [XLEN-1:0]       rs1_val; // after forwarding.
  logic [XLEN-1:0]       rs2_val;
  logic                  hazard;

  modport res (
    input  rs1, rs2, uses_rs,
    output rs1_val, rs2_val, hazard
  );

  modport stage (
    output rs1, rs2, uses_rs,
    input  rs1_val, rs2_val, hazard
  );

endinterface

`default_nettype wire

// File: design/inst_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module inst_decoder (
  input  logic [idu_pkg::INST_W-1:0] inst_i,
  decode_if.dec                      dec
);
  import idu_pkg::*;

  localparam int IMM_W = $bits(dec.imm);

  opcode_e             opcode;
  logic [FUNCT3_W-1:0] funct3;
  logic                alt;
  logic                sign;
  logic [INST_W-1:0]   imm_i;
  logic [INST_W-1:0]   imm_s;
  logic [INST_W-1:0]   imm_b;
  logic [INST_W-1:0]   imm_u;
  logic [INST_W-1:0]   imm_j;
  logic [INST_W-1:0]   imm_raw;

  // shared by op and op_imm.
  function automatic alu_op_e arith_op(input logic [FUNCT3_W-1:0] f3, input logic alt_sel);
    alu_op_e op;
    case (f3)
      3'b000:  op = alt_sel ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt_sel ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  function automatic alu_op_e branch_op(input logic [FUNCT3_W-1:0] f3);
    alu_op_e op;
    case (f3)
      3'b000:  op = ALU_BEQ;
      3'b001:  op = ALU_BNE;
      3'b100:  op = ALU_BLT;
      3'b101:  op = ALU_BGE;
      3'b110:  op = ALU_BLTU;
      3'b111:  op = ALU_BGEU;
      default: op = ALU_ADD; // reserved funct3.
    endcase
    return op;
  endfunction

  assign opcode = opcode_e'(inst_i[OPCODE_LSB +: OPCODE_W]);
  assign funct3 = inst_i[FUNCT3_LSB +: FUNCT3_W];
  assign alt    = inst_i[ALT_BIT];
  assign sign   = inst_i[SIGN_BIT];

  assign imm_i = {{20{sign}}, inst_i[31:20]};
  assign imm_s = {{20{sign}}, inst_i[31:25], inst_i[11:7]};
  assign imm_b = {{19{sign}}, sign, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
  assign imm_u = {inst_i[31:12], 12'b0};
  assign imm_j = {{11{sign}}, sign, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

  assign dec.rs1 = inst_i[RS1_LSB +: REG_ADDR_W];
  assign dec.rs2 = inst_i[RS2_LSB +: REG_ADDR_W];
  assign dec.rd  = inst_i[RD_LSB +: REG_ADDR_W];
  assign dec.imm = IMM_W'($signed(imm_raw)); // sign extend to xlen.

  assign dec.ebreak = (inst_i == EBREAK_INST);

  always_comb begin
    imm_raw               = '0;
    dec.alu_op            = ALU_ADD;
    dec.uses_rs           = 1'b0;
    dec.wen               = 1'b0;
    dec.ren               = 1'b0;
    dec.jen               = 1'b0;
    dec.system            = 1'b0;
    dec.system_func3_zero = 1'b0;
    dec.csr_wen           = 1'b0;
    case (opcode)
      OPC_LUI, OPC_AUIPC: begin
        imm_raw = imm_u;
        dec.wen = 1'b1;
      end
      OPC_JAL: begin
        imm_raw = imm_j;
        dec.wen = 1'b1;
        dec.jen = 1'b1;
      end
      OPC_JALR: begin
        imm_raw     = imm_i;
        dec.uses_rs = 1'b1;
        dec.wen     = 1'b1;
        dec.jen     = 1'b1;
      end
      OPC_BRANCH: begin
        imm_raw     = imm_b;
        dec.uses_rs = 1'b1;
        dec.jen     = 1'b1;
        dec.alu_op  = branch_op(funct3);
      end
      OPC_LOAD: begin
        imm_raw     = imm_i;
        dec.uses_rs = 1'b1;
        dec.wen     = 1'b1;
        dec.ren     = 1'b1;
      end
      OPC_STORE: begin
        imm_raw     = imm_s;
        dec.uses_rs = 1'b1;
      end
      OPC_OP_IMM: begin
        imm_raw     = imm_i;
        dec.uses_rs = 1'b1;
        dec.wen     = 1'b1;
        dec.alu_op  = arith_op(funct3, alt && (funct3 == 3'b101)); // only srai uses bit 30.
      end
      OPC_OP: begin
        dec.uses_rs = 1'b1;
        dec.wen     = 1'b1;
        dec.alu_op  = arith_op(funct3, alt);
      end
      OPC_SYSTEM: begin
        imm_raw               = imm_i;
        dec.uses_rs           = 1'b1;
        dec.system            = 1'b1;
        dec.system_func3_zero = (funct3 == 3'b000);
        dec.csr_wen           = (funct3 != 3'b000);
        dec.wen               = (funct3 != 3'b000); // csr old value goes to rd.
      end
      default: ;
    endcase
  end

  // a store must not reach the write-back or load path.
  always_comb begin
    a_store_no_wb: assert final (!(opcode == OPC_STORE && (dec.wen || dec.ren)));
  end

endmodule

`default_nettype wire

// File: design/operand_resolver.sv
`timescale 1ns/100ps
`default_nettype none

module operand_resolver #(
  parameter int XLEN = 32
) (
  input  logic                            full_i,
  operand_if.res                          opnd,
  input  logic [XLEN-1:0]                 rdata1_i,
  input  logic [XLEN-1:0]                 rdata2_i,
  input  logic [idu_pkg::NUM_REGS-1:0]    rf_busy_i,
  input  logic                            exu_valid_i,
  input  logic [XLEN-1:0]                 exu_fwd_i,
  input  logic [idu_pkg::REG_ADDR_W-1:0]  exu_fwd_rd_i
);

  logic fwd1;
  logic fwd2;
  logic stall1;
  logic stall2;

  // execute result bypasses the register file.
  assign fwd1 = exu_valid_i && (opnd.rs1 == exu_fwd_rd_i);
  assign fwd2 = exu_valid_i && (opnd.rs2 == exu_fwd_rd_i);

  assign opnd.rs1_val = fwd1 ? exu_fwd_i : rdata1_i;
  assign opnd.rs2_val = fwd2 ? exu_fwd_i : rdata2_i;

  // busy in the scoreboard and not covered by forwarding.
  assign stall1 = rf_busy_i[opnd.rs1] && !fwd1;
  assign stall2 = rf_busy_i[opnd.rs2] && !fwd2;

  assign opnd.hazard = full_i && opnd.uses_rs && (stall1 || stall2);

  // an empty slot never stalls the stage.
  always_comb begin
    a_no_hazard_empty: assert final (full_i || !opnd.hazard);
  end

endmodule

`default_nettype wire

// File: design/decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

module decode_stage #(
  parameter int XLEN = 32
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [idu_pkg::INST_W-1:0]  inst_i,
  input  logic [XLEN-1:0]             pc_i,
  input  logic                        spec_i,
  input  logic                        prev_valid_i,
  input  logic                        next_ready_i,
  decode_if.stage                     dec,
  operand_if.stage                    opnd,
  output logic [idu_pkg::INST_W-1:0]  inst_o,
  output logic [XLEN-1:0]             pc_o,
  output logic                        full_o,
  output logic                        valid_o,
  output logic                        ready_o,
  output logic                        spec_o,
  output logic [XLEN-1:0]             op1_o,
  output logic [XLEN-1:0]             op2_o,
  output logic [XLEN-1:0]             op_j_o
);
  import idu_pkg::*;

  logic              full_q;
  logic [INST_W-1:0] inst_q;
  logic [XLEN-1:0]   pc_q;
  logic              spec_q;
  logic              accept;
  logic              depart;
  opcode_e           opcode;

  assign valid_o = full_q && !opnd.hazard;
  assign ready_o = !full_q || (valid_o && next_ready_i);
  assign accept  = prev_valid_i && ready_o;
  assign depart  = valid_o && next_ready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      full_q <= 1'b0;
      inst_q <= '0;
    end else if (accept) begin
      full_q <= 1'b1;
      inst_q <= inst_i;
    end else if (depart) begin
      full_q <= 1'b0;
      inst_q <= '0; // empty slot decodes as nothing.
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      pc_q   <= pc_i;
      spec_q <= spec_i;
    end
  end

  assign inst_o = inst_q;
  assign pc_o   = pc_q;
  assign spec_o = spec_q;
  assign full_o = full_q;

  assign opnd.rs1     = dec.rs1;
  assign opnd.rs2     = dec.rs2;
  assign opnd.uses_rs = dec.uses_rs;

  assign opcode = opcode_e'(inst_q[OPCODE_LSB +: OPCODE_W]);

  always_comb begin
    op1_o  = '0;
    op2_o  = '0;
    op_j_o = '0;
    case (opcode)
      OPC_LUI:   op2_o = dec.imm;
      OPC_AUIPC: begin
        op1_o = pc_q;
        op2_o = dec.imm;
      end
      OPC_JAL: begin
        op1_o  = pc_q;
        op2_o  = XLEN'(4); // link address.
        op_j_o = pc_q;
      end
      OPC_JALR: begin
        op1_o  = pc_q;
        op2_o  = XLEN'(4);
        op_j_o = opnd.rs1_val;
      end
      OPC_BRANCH: begin
        op1_o  = opnd.rs1_val;
        op2_o  = opnd.rs2_val;
        op_j_o = pc_q;
      end
      OPC_OP: begin
        op1_o = opnd.rs1_val;
        op2_o = opnd.rs2_val;
      end
      OPC_LOAD: begin
        op1_o  = opnd.rs1_val;
        op2_o  = dec.imm;
        op_j_o = opnd.rs1_val;
      end
      OPC_STORE: begin
        op1_o  = opnd.rs1_val;
        op2_o  = opnd.rs2_val; // store data.
        op_j_o = opnd.rs1_val;
      end
      OPC_OP_IMM, OPC_SYSTEM: begin
        op1_o = opnd.rs1_val;
        op2_o = dec.imm;
      end
      default: ;
    endcase
  end

  // hazard comes back from the resolver.
  a_no_valid_on_hazard: assert property (@(posedge clk) disable iff (rst)
    valid_o |-> !opnd.hazard);

  a_hold_when_stalled: assert property (@(posedge clk) disable iff (rst)
    (valid_o && !next_ready_i) |=> ($stable(inst_o) && $stable(pc_o)));

endmodule

`default_nettype wire

// File: design/idu_top.sv
`timescale 1ns/100ps
`default_nettype none

module idu_top #(
  parameter int XLEN = 32
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [idu_pkg::INST_W-1:0]     inst_i,
  input  logic [XLEN-1:0]                pc_i,
  input  logic                           spec_i,
  input  logic                           prev_valid_i,
  input  logic                           next_ready_i,
  input  logic [XLEN-1:0]                rdata1_i,
  input  logic [XLEN-1:0]                rdata2_i,
  input  logic [idu_pkg::NUM_REGS-1:0]   rf_busy_i,
  input  logic                           exu_valid_i,
  input  logic [XLEN-1:0]                exu_fwd_i,
  input  logic [idu_pkg::REG_ADDR_W-1:0] exu_fwd_rd_i,
  output logic                           valid_o,
  output logic                           ready_o,
  output logic [idu_pkg::INST_W-1:0]     inst_o,
  output logic [XLEN-1:0]                pc_o,
  output logic                           spec_o,
  output logic [idu_pkg::REG_ADDR_W-1:0] rs1_o,
  output logic [idu_pkg::REG_ADDR_W-1:0] rs2_o,
  output logic [idu_pkg::REG_ADDR_W-1:0] rd_o,
  output logic [XLEN-1:0]                imm_o,
  output idu_pkg::alu_op_e               alu_op_o,
  output logic [XLEN-1:0]                op1_o,
  output logic [XLEN-1:0]                op2_o,
  output logic [XLEN-1:0]                op_j_o,
  output logic                           wen_o,
  output logic                           ren_o,
  output logic                           jen_o,
  output logic                           system_o,
  output logic                           system_func3_zero_o,
  output logic                           csr_wen_o,
  output logic                           ebreak_o
);

  logic full;

  decode_if  #(.XLEN(XLEN)) dec_bus ();
  operand_if #(.XLEN(XLEN)) opnd_bus ();

  decode_stage #(.XLEN(XLEN)) u_stage (
    .clk          (clk),
    .rst          (rst),
    .inst_i       (inst_i),
    .pc_i         (pc_i),
    .spec_i       (spec_i),
    .prev_valid_i (prev_valid_i),
    .next_ready_i (next_ready_i),
    .dec          (dec_bus),
    .opnd         (opnd_bus),
    .inst_o       (inst_o),
    .pc_o         (pc_o),
    .full_o       (full),
    .valid_o      (valid_o),
    .ready_o      (ready_o),
    .spec_o       (spec_o),
    .op1_o        (op1_o),
    .op2_o        (op2_o),
    .op_j_o       (op_j_o)
  );

  // decodes the held instruction.
  inst_decoder u_decoder (
    .inst_i (inst_o),
    .dec    (dec_bus)
  );

  operand_resolver #(.XLEN(XLEN)) u_resolver (
    .full_i       (full),
    .opnd         (opnd_bus),
    .rdata1_i     (rdata1_i),
    .rdata2_i     (rdata2_i),
    .rf_busy_i    (rf_busy_i),
    .exu_valid_i  (exu_valid_i),
    .exu_fwd_i    (exu_fwd_i),
    .exu_fwd_rd_i (exu_fwd_rd_i)
  );

  assign rs1_o               = dec_bus.rs1; // register file read address.
  assign rs2_o               = dec_bus.rs2;
  assign rd_o                = dec_bus.rd;
  assign imm_o               = dec_bus.imm;
  assign alu_op_o            = dec_bus.alu_op;
  assign wen_o               = dec_bus.wen;
  assign ren_o               = dec_bus.ren;
  assign jen_o               = dec_bus.jen;
  assign system_o            = dec_bus.system;
  assign system_func3_zero_o = dec_bus.system_func3_zero;
  assign csr_wen_o           = dec_bus.csr_wen;
  assign ebreak_o            = dec_bus.ebreak;

endmodule

`default_nettype wire

// File: bench/tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
  parameter real PERIOD = 4.0
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2.0) clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

// File: bench/tb_idu.sv
`timescale 1ns/100ps
`default_nettype none

module tb_idu;
  import idu_pkg::*;

  localparam int XLEN       = 32;
  localparam int NUM_INST   = 400;
  localparam int RUN_MAX    = 20000;
  localparam int STALL_MAX  = 40;
  localparam int ACCEPT_MAX = 64;

  // bit order of the control word from ctrl_model.
  localparam int C_USES = 7;
  localparam int C_WEN  = 6;
  localparam int C_REN  = 5;
  localparam int C_JEN  = 4;
  localparam int C_SYS  = 3;
  localparam int C_F3Z  = 2;
  localparam int C_CSR  = 1;
  localparam int C_EBRK = 0;

  logic            clk;
  logic            rst;
  logic [31:0]     inst_i;
  logic [XLEN-1:0] pc_i;
  logic            spec_i;
  logic            prev_valid_i;
  logic            next_ready_i;
  logic [XLEN-1:0] rdata1_i;
  logic [XLEN-1:0] rdata2_i;
  logic [15:0]     rf_busy_i;
  logic            exu_valid_i;
  logic [XLEN-1:0] exu_fwd_i;
  logic [3:0]      exu_fwd_rd_i;
  logic            valid_o;
  logic            ready_o;
  logic [31:0]     inst_o;
  logic [XLEN-1:0] pc_o;
  logic            spec_o;
  logic [3:0]      rs1_o;
  logic [3:0]      rs2_o;
  logic [3:0]      rd_o;
  logic [XLEN-1:0] imm_o;
  alu_op_e         alu_op_o;
  logic [XLEN-1:0] op1_o;
  logic [XLEN-1:0] op2_o;
  logic [XLEN-1:0] op_j_o;
  logic            wen_o;
  logic            ren_o;
  logic            jen_o;
  logic            system_o;
  logic            system_func3_zero_o;
  logic            csr_wen_o;
  logic            ebreak_o;

  int              seed;
  logic [XLEN-1:0] rf [16];
  logic [31:0]     q_inst [$];
  logic [XLEN-1:0] q_pc [$];
  logic            q_spec [$];
  logic [31:0]     offer_inst;
  logic [XLEN-1:0] offer_pc;
  logic            offer_spec;
  logic [XLEN-1:0] next_pc;
  int              accepted;
  int              departed;
  int              offer_wait;
  int              stall_run;
  int              stall_cycles;
  int              fwd_busy_hits;
  int              cycles;

  tb_clock #(.PERIOD(4.0)) clk_gen (.clk_o(clk));

  idu_top #(.XLEN(XLEN)) UUT (
    .clk                 (clk),
    .rst                 (rst),
    .inst_i              (inst_i),
    .pc_i                (pc_i),
    .spec_i              (spec_i),
    .prev_valid_i        (prev_valid_i),
    .next_ready_i        (next_ready_i),
    .rdata1_i            (rdata1_i),
    .rdata2_i            (rdata2_i),
    .rf_busy_i           (rf_busy_i),
    .exu_valid_i         (exu_valid_i),
    .exu_fwd_i           (exu_fwd_i),
    .exu_fwd_rd_i        (exu_fwd_rd_i),
    .valid_o             (valid_o),
    .ready_o             (ready_o),
    .inst_o              (inst_o),
    .pc_o                (pc_o),
    .spec_o              (spec_o),
    .rs1_o               (rs1_o),
    .rs2_o               (rs2_o),
    .rd_o                (rd_o),
    .imm_o               (imm_o),
    .alu_op_o            (alu_op_o),
    .op1_o               (op1_o),
    .op2_o               (op2_o),
    .op_j_o              (op_j_o),
    .wen_o               (wen_o),
    .ren_o               (ren_o),
    .jen_o               (jen_o),
    .system_o            (system_o),
    .system_func3_zero_o (system_func3_zero_o),
    .csr_wen_o           (csr_wen_o),
    .ebreak_o            (ebreak_o)
  );

  assign rdata1_i = rf[rs1_o]; // asynchronous register file read.
  assign rdata2_i = rf[rs2_o];

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "run aborted");
  endtask

  task automatic check_val(input string name, input logic [63:0] actual,
                           input logic [63:0] expected);
    if (actual !== expected) begin
      $display("ERROR %s actual 0x%0h expected 0x%0h", name, actual, expected);
      $display("STATUS: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // legal rv32e encodings with random fields.
  task automatic gen_inst(output logic [31:0] inst);
    logic [31:0] w;
    logic [2:0]  f3;
    int unsigned kind;
    w        = rand32();
    kind     = rand32() % 11;
    inst     = w;
    inst[11] = 1'b0; // register fields stay below 16.
    inst[19] = 1'b0;
    inst[24] = 1'b0;
    f3       = w[14:12];
    case (kind)
      0: inst[6:0] = 7'b011_0111;
      1: inst[6:0] = 7'b001_0111;
      2: inst[6:0] = 7'b110_1111;
      3: inst[14:0] = {3'b000, inst[11:7], 7'b110_0111};
      4: begin
        if (f3[2:1] == 2'b01) f3[1] = 1'b0; // no reserved compares.
        inst[14:0] = {f3, inst[11:7], 7'b110_0011};
      end
      5: begin
        if (f3 == 3'b011 || f3[2:1] == 2'b11) f3 = 3'b010;
        inst[14:0] = {f3, inst[11:7], 7'b000_0011};
      end
      6: begin
        f3 = {1'b0, f3[1:0]};
        if (f3 == 3'b011) f3 = 3'b000;
        inst[14:0] = {f3, inst[11:7], 7'b010_0011};
      end
      7: begin
        if (f3 == 3'b001) inst[31:25] = 7'b0;
        if (f3 == 3'b101) inst[31:25] = {1'b0, w[30], 5'b0};
        inst[14:0] = {f3, inst[11:7], 7'b001_0011};
      end
      8: begin
        inst[31:25] = (f3 == 3'b000 || f3 == 3'b101) ? {1'b0, w[30], 5'b0} : 7'b0;
        inst[14:0]  = {f3, inst[11:7], 7'b011_0011};
      end
      9: begin
        if (f3 == 3'b100) f3 = 3'b001;
        if (f3 == 3'b000) inst = w[20] ? 32'h0010_0073 : 32'h0000_0073;
        else inst[14:0] = {f3, inst[11:7], 7'b111_0011};
      end
      default: inst = 32'h0010_0073; // ebreak.
    endcase
  endtask

  function automatic logic [XLEN-1:0] imm_model(input logic [31:0] i);
    case (i[6:0])
      OPC_LUI, OPC_AUIPC: return XLEN'($signed({i[31:12], 12'h000}));
      OPC_JALR, OPC_LOAD, OPC_OP_IMM, OPC_SYSTEM: return XLEN'($signed(i[31:20]));
      OPC_STORE:  return XLEN'($signed({i[31:25], i[11:7]}));
      OPC_BRANCH: return XLEN'($signed({i[31], i[7], i[30:25], i[11:8], 1'b0}));
      OPC_JAL:    return XLEN'($signed({i[31], i[19:12], i[20], i[30:21], 1'b0}));
      default:    return '0;
    endcase
  endfunction

  function automatic alu_op_e arith_model(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  function automatic alu_op_e alu_model(input logic [31:0] i);
    if (i[6:0] == OPC_OP) return arith_model(i[14:12], i[30]);
    if (i[6:0] == OPC_OP_IMM) return arith_model(i[14:12], i[30] && i[14:12] == 3'b101);
    if (i[6:0] == OPC_BRANCH) begin
      case (i[14:12])
        3'b000:  return ALU_BEQ;
        3'b001:  return ALU_BNE;
        3'b100:  return ALU_BLT;
        3'b101:  return ALU_BGE;
        3'b110:  return ALU_BLTU;
        3'b111:  return ALU_BGEU;
        default: return ALU_ADD;
      endcase
    end
    return ALU_ADD;
  endfunction

  function automatic logic [7:0] ctrl_model(input logic [31:0] i);
    logic [7:0] c;
    logic       f3z;
    c   = 8'h00;
    f3z = (i[14:12] == 3'b000);
    case (i[6:0])
      OPC_LUI, OPC_AUIPC: c[C_WEN] = 1'b1;
      OPC_JAL: c = c | (8'h1 << C_WEN) | (8'h1 << C_JEN);
      OPC_JALR: c = c | (8'h1 << C_USES) | (8'h1 << C_WEN) | (8'h1 << C_JEN);
      OPC_BRANCH: c = c | (8'h1 << C_USES) | (8'h1 << C_JEN);
      OPC_LOAD: c = c | (8'h1 << C_USES) | (8'h1 << C_WEN) | (8'h1 << C_REN);
      OPC_STORE: c[C_USES] = 1'b1;
      OPC_OP_IMM, OPC_OP: c = c | (8'h1 << C_USES) | (8'h1 << C_WEN);
      OPC_SYSTEM: begin
        c[C_USES] = 1'b1;
        c[C_SYS]  = 1'b1;
        c[C_F3Z]  = f3z;
        c[C_CSR]  = !f3z;
        c[C_WEN]  = !f3z; // csr read result lands in rd.
      end
      default: ;
    endcase
    c[C_EBRK] = (i == 32'h0010_0073);
    return c;
  endfunction

  task automatic operand_model(input logic [31:0] i, input logic [XLEN-1:0] pc,
                               input logic [XLEN-1:0] v1, input logic [XLEN-1:0] v2,
                               output logic [XLEN-1:0] op1, output logic [XLEN-1:0] op2,
                               output logic [XLEN-1:0] opj);
    logic [XLEN-1:0] imm;
    imm = imm_model(i);
    op1 = '0;
    op2 = '0;
    opj = '0;
    case (i[6:0])
      OPC_LUI: op2 = imm;
      OPC_AUIPC: begin
        op1 = pc;
        op2 = imm;
      end
      OPC_JAL, OPC_JALR: begin
        op1 = pc;
        op2 = XLEN'(4);
        opj = (i[6:0] == OPC_JAL) ? pc : v1;
      end
      OPC_OP, OPC_BRANCH, OPC_STORE: begin
        op1 = v1;
        op2 = v2;
        if (i[6:0] == OPC_BRANCH) opj = pc;
        if (i[6:0] == OPC_STORE) opj = v1;
      end
      OPC_OP_IMM, OPC_LOAD, OPC_SYSTEM: begin
        op1 = v1;
        op2 = imm;
        if (i[6:0] == OPC_LOAD) opj = v1;
      end
      default: ;
    endcase
  endtask

  task automatic drive_inputs();
    logic [31:0] r;
    logic [31:0] t;
    logic [31:0] held;
    r    = rand32();
    held = 32'h0;
    if (q_inst.size() != 0) held = q_inst[0];
    prev_valid_i = (accepted < NUM_INST) && (r[1:0] != 2'b00);
    next_ready_i = (r[3:2] != 2'b00);
    inst_i       = offer_inst;
    pc_i         = offer_pc;
    spec_i       = offer_spec;
    t            = rand32();
    rf_busy_i    = rf_busy_i & t[15:0]; // results retire over time.
    if (r[6:4] == 3'b000) begin
      t         = rand32();
      rf_busy_i = rf_busy_i | t[15:0];
    end
    rf_busy_i[0] = 1'b0;
    t            = rand32();
    if (r[7]) rf[r[11:8]] = t;
    rf[0]       = '0;
    exu_valid_i = r[12];
    exu_fwd_i   = rand32();
    case (r[14:13])
      2'b00:   exu_fwd_rd_i = held[18:15];
      2'b01:   exu_fwd_rd_i = held[23:20];
      default: exu_fwd_rd_i = r[19:16];
    endcase
  endtask

  task automatic check_cycle();
    logic [31:0]     held;
    logic            full;
    logic [7:0]      ctrl;
    logic [3:0]      a1;
    logic [3:0]      a2;
    logic            fwd1;
    logic            fwd2;
    logic            busy1;
    logic            busy2;
    logic            hazard;
    logic            exp_valid;
    logic            exp_ready;
    logic [XLEN-1:0] v1;
    logic [XLEN-1:0] v2;
    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    logic [XLEN-1:0] opj;
    full = (q_inst.size() != 0);
    held = 32'h0;
    if (full) held = q_inst[0];
    ctrl      = ctrl_model(held);
    a1        = held[18:15];
    a2        = held[23:20];
    fwd1      = exu_valid_i && (exu_fwd_rd_i == a1);
    fwd2      = exu_valid_i && (exu_fwd_rd_i == a2);
    busy1     = rf_busy_i[a1];
    busy2     = rf_busy_i[a2];
    v1        = fwd1 ? exu_fwd_i : rf[a1];
    v2        = fwd2 ? exu_fwd_i : rf[a2];
    hazard    = full && ctrl[C_USES] && ((busy1 && !fwd1) || (busy2 && !fwd2));
    exp_valid = full && !hazard;
    exp_ready = !full || (exp_valid && next_ready_i);
    check_val("inst_o", 64'(inst_o), 64'(held));
    check_val("rs1_o", 64'(rs1_o), 64'(a1));
    check_val("rs2_o", 64'(rs2_o), 64'(a2));
    check_val("valid_o", 64'(valid_o), 64'(exp_valid));
    check_val("ready_o", 64'(ready_o), 64'(exp_ready));
    if (full) begin
      check_val("pc_o", 64'(pc_o), 64'(q_pc[0]));
      check_val("spec_o", 64'(spec_o), 64'(q_spec[0]));
    end
    if (hazard) stall_cycles++;
    stall_run = (full && !exp_valid) ? stall_run + 1 : 0;
    if (stall_run > STALL_MAX) abort_run("valid_o stayed low long after the hazard should clear");
    if (exp_valid && next_ready_i) begin
      operand_model(held, q_pc[0], v1, v2, op1, op2, opj);
      check_val("rd_o", 64'(rd_o), 64'(held[10:7]));
      check_val("imm_o", 64'(imm_o), 64'(imm_model(held)));
      check_val("alu_op_o", 64'(alu_op_o), 64'(alu_model(held)));
      check_val("wen_o", 64'(wen_o), 64'(ctrl[C_WEN]));
      check_val("ren_o", 64'(ren_o), 64'(ctrl[C_REN]));
      check_val("jen_o", 64'(jen_o), 64'(ctrl[C_JEN]));
      check_val("system_o", 64'(system_o), 64'(ctrl[C_SYS]));
      check_val("system_func3_zero_o", 64'(system_func3_zero_o), 64'(ctrl[C_F3Z]));
      check_val("csr_wen_o", 64'(csr_wen_o), 64'(ctrl[C_CSR]));
      check_val("ebreak_o", 64'(ebreak_o), 64'(ctrl[C_EBRK]));
      check_val("op1_o", 64'(op1_o), 64'(op1));
      check_val("op2_o", 64'(op2_o), 64'(op2));
      check_val("op_j_o", 64'(op_j_o), 64'(opj));
      if (ctrl[C_USES] && ((busy1 && fwd1) || (busy2 && fwd2))) fwd_busy_hits++;
      void'(q_inst.pop_front());
      void'(q_pc.pop_front());
      void'(q_spec.pop_front());
      departed++;
    end
    offer_wait++;
    if (prev_valid_i && exp_ready) begin
      q_inst.push_back(offer_inst);
      q_pc.push_back(offer_pc);
      q_spec.push_back(offer_spec);
      accepted++;
      offer_wait = 0;
      gen_inst(offer_inst);
      next_pc    = next_pc + XLEN'(4);
      offer_pc   = next_pc;
      offer_spec = rand32() % 2 == 1;
    end
    if (accepted < NUM_INST && offer_wait > ACCEPT_MAX)
      abort_run("the stage did not accept an offered instruction in time");
  endtask

  initial begin
    seed          = 3903;
    rst           = 1'b1;
    inst_i        = '0;
    pc_i          = '0;
    spec_i        = 1'b0;
    prev_valid_i  = 1'b0;
    next_ready_i  = 1'b0;
    rf_busy_i     = '0;
    exu_valid_i   = 1'b0;
    exu_fwd_i     = '0;
    exu_fwd_rd_i  = '0;
    accepted      = 0;
    departed      = 0;
    offer_wait    = 0;
    stall_run     = 0;
    stall_cycles  = 0;
    fwd_busy_hits = 0;
    foreach (rf[k]) rf[k] = rand32();
    rf[0]      = '0;
    next_pc    = rand32() & ~32'h3;
    offer_pc   = next_pc;
    offer_spec = 1'b0;
    gen_inst(offer_inst);

    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    #1;
    check_val("valid_o", 64'(valid_o), 64'h0);
    check_val("ready_o", 64'(ready_o), 64'h1);

    cycles = 0;
    while (departed < NUM_INST) begin
      if (cycles >= RUN_MAX) abort_run("instructions did not all leave the stage in time");
      @(negedge clk);
      drive_inputs();
      #1; // outputs settle before the next rising edge.
      check_cycle();
      cycles++;
    end

    @(negedge clk);
    drive_inputs();
    #1; // the drained stage holds nothing.
    check_cycle();

    if (fwd_busy_hits == 0) begin
      abort_run("no forwarded operand over a busy register was seen");
    end else if (stall_cycles == 0) begin
      abort_run("no hazard stall was seen");
    end else begin
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: all.f
design/idu_pkg.sv
design/decode_if.sv
design/operand_if.sv
design/inst_decoder.sv
design/operand_resolver.sv
design/decode_stage.sv
design/idu_top.sv
bench/tb_clock.sv
bench/tb_idu.sv

// File: Makefile
# Verilator build of the decode stage testbench.

OBJ_DIR := obj_dir
LOG     := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module tb_idu -Mdir $(OBJ_DIR) -f all.f

run: compile
	./$(OBJ_DIR)/Vtb_idu | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
